// File: common/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	// codes of the full FPU, only the divide is served by this unit
	typedef enum logic [4:0] {
		FPU_OP_ADD  = 5'd0,
		FPU_OP_SUB  = 5'd1,
		FPU_OP_MUL  = 5'd2,
		FPU_OP_DIV  = 5'd3,
		FPU_OP_SQRT = 5'd4,
		FPU_OP_CMP  = 5'd5,
		FPU_OP_CVT  = 5'd6
	} fpu_op_t;

	typedef logic [2:0] round_mode_t;

	localparam round_mode_t RM_RNE = 3'd0;
	localparam round_mode_t RM_RTZ = 3'd1;
	localparam round_mode_t RM_RDN = 3'd2;
	localparam round_mode_t RM_RUP = 3'd3;
	localparam round_mode_t RM_RMM = 3'd4;

	localparam int FLAG_W  = 5;
	localparam int FLAG_NV = 4;
	localparam int FLAG_DZ = 3;
	localparam int FLAG_OF = 2;
	localparam int FLAG_UF = 1;
	localparam int FLAG_NX = 0;

endpackage

`default_nettype wire

// File: common/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

	localparam int MAN_W  = 24;	// mantissa including the hidden bit
	localparam int FRAC_W = 23;
	localparam int BEXP_W = 8;	// exponent field of the word
	localparam int EXP_W  = 10;	// internal exponent, signed
	localparam int BIAS   = 127;

	localparam logic [BEXP_W-1:0] EXP_SPECIAL = 8'hff;	// infinity and NaN
	localparam logic [BEXP_W-1:0] EXP_MAXNORM = 8'hfe;

	localparam logic [31:0] QNAN_CANON = 32'h7fc00000;

	typedef struct packed {
		logic              sgn;
		logic [BEXP_W-1:0] exp;
		logic [FRAC_W-1:0] frac;
	} fp32_fields_t;

	// the unpacker looks at the same word as raw bits and as fields
	typedef union packed {
		logic [31:0]  bits;
		fp32_fields_t f;
	} fp32_word_t;

endpackage

`default_nettype wire

// File: common/fp_operand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fp_operand_if;

	logic [fp_format_pkg::MAN_W-1:0] man;
	logic [fp_format_pkg::EXP_W-1:0] exp;	// biased, zero extended
	logic                            sgn;
	logic                            zero;
	logic                            inf;
	logic                            snan;
	logic                            qnan;

	modport src (
		output man, exp, sgn, zero, inf, snan, qnan
	);

	modport dst (
		input man, exp, sgn, zero, inf, snan, qnan
	);

endinterface

`default_nettype wire

// File: common/fp_quotient_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fp_quotient_if;

	logic [fp_format_pkg::MAN_W-1:0] man;
	logic [fp_format_pkg::EXP_W-1:0] exp;	// unbiased exponent difference
	logic                            sgn;
	logic                            round_bit;
	logic                            sticky_bit;
	logic                            skip_round;	// word is final, pack as is
	logic                            iv;
	logic                            dz;
	fpu_pkg::round_mode_t            rm;
	logic                            valid;
	logic                            ready;

	modport prod (
		output man, exp, sgn, round_bit, sticky_bit, skip_round, iv, dz, rm, valid,
		input  ready
	);

	modport cons (
		input  man, exp, sgn, round_bit, sticky_bit, skip_round, iv, dz, rm, valid,
		output ready
	);

endinterface

`default_nettype wire

// File: src/float_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module float_unpacker (
	input  wire logic [31:0] word,
	fp_operand_if.src        op
);

	localparam int FRAC_W = fp_format_pkg::FRAC_W;
	localparam int EXP_W  = fp_format_pkg::EXP_W;
	localparam int BEXP_W = fp_format_pkg::BEXP_W;

	// magnitude of infinity, anything above it is a NaN
	localparam logic [30:0] INF_MAG = {fp_format_pkg::EXP_SPECIAL, {FRAC_W{1'b0}}};

	fp_format_pkg::fp32_word_t w;

	logic exp_zero;
	logic exp_ones;
	logic nan;

	assign w = word;

	assign exp_zero = w.f.exp == '0;	// subnormals flush to zero here
	assign exp_ones = w.f.exp == fp_format_pkg::EXP_SPECIAL;
	assign nan      = w.bits[30:0] > INF_MAG;

	assign op.sgn  = w.f.sgn;
	assign op.zero = exp_zero;
	assign op.inf  = exp_ones && w.f.frac == '0;
	assign op.qnan = nan && w.bits[FRAC_W-1];	// quiet bit is the top fraction bit
	assign op.snan = nan && !w.bits[FRAC_W-1];

	assign op.exp = exp_zero ? '0 : {{(EXP_W-BEXP_W){1'b0}}, w.f.exp};
	assign op.man = exp_zero ? '0 : {1'b1, w.f.frac};

endmodule

`default_nettype wire

// File: float_divider/float_divider.sv
`timescale 1ns/1ps
`default_nettype none

module float_divider #(
	parameter int ITERS = 13	// two quotient bits per iteration, at least 13
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic [4:0] op,
	input  wire logic [2:0] rm,
	fp_operand_if.dst       a,
	fp_operand_if.dst       b,
	input  wire logic       in_valid,
	output logic            in_ready,
	fp_quotient_if.prod     q
);

	localparam int MAN_W  = fp_format_pkg::MAN_W;
	localparam int EXP_W  = fp_format_pkg::EXP_W;
	localparam int FRAC_W = fp_format_pkg::FRAC_W;
	localparam int RES_W  = 2 * ITERS;
	localparam int REM_W  = MAN_W + 3;
	localparam int CNT_W  = $clog2(ITERS);

	localparam logic [MAN_W-1:0] NAN_MAN = {1'b1, fp_format_pkg::QNAN_CANON[FRAC_W-1:0]};
	localparam logic [MAN_W-1:0] INF_MAN = {1'b1, {FRAC_W{1'b0}}};
	localparam logic [EXP_W-1:0] SPC_EXP = EXP_W'(fp_format_pkg::EXP_SPECIAL);

	typedef enum logic {IDLE, CALC} state_t;

	state_t             state;
	logic [CNT_W-1:0]   count;
	logic               valid_q;

	logic [MAN_W-1:0]   div_man;
	logic [RES_W-1:0]   res_q;
	logic [REM_W-1:0]   rem_q;
	logic [EXP_W-1:0]   exp_q;
	logic               sgn_q;
	logic               skip_q;
	logic               iv_q;
	logic               dz_q;
	logic [2:0]         rm_q;

	logic               accept;
	logic               nan_case;
	logic               inf_case;
	logic               zero_case;
	logic               invalid;

	logic [REM_W-1:0]   step [0:2];
	logic [REM_W-1:0]   diff [1:2];
	logic [1:0]         qbits;

	logic               norm_shift;
	logic [RES_W-1:0]   norm;

	assign in_ready = q.ready && state == IDLE && op == fpu_pkg::FPU_OP_DIV;
	assign accept   = in_valid && in_ready;

	assign invalid   = a.snan || b.snan || (a.zero && b.zero) || (a.inf && b.inf);
	assign nan_case  = invalid || a.qnan || b.qnan;
	assign inf_case  = a.inf || b.zero;	// only checked once nan_case is clear
	assign zero_case = a.zero || b.inf;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state   <= IDLE;
			count   <= '0;
			valid_q <= 1'b0;
		end else if (accept) begin
			count <= '0;
			if (nan_case || inf_case || zero_case) begin
				valid_q <= 1'b1;	// settled on the accepting edge
				state   <= IDLE;
			end else begin
				valid_q <= 1'b0;
				state   <= CALC;
			end
		end else if (state == CALC) begin
			if (count == CNT_W'(ITERS - 1)) begin
				valid_q <= 1'b1;
				state   <= IDLE;
			end else begin
				count <= count + 1'b1;
			end
		end else if (valid_q && q.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			div_man <= b.man;
			res_q   <= '0;
			rem_q   <= {1'b0, a.man, 2'b00};
			exp_q   <= a.exp - b.exp;
			sgn_q   <= a.sgn ^ b.sgn;
			skip_q  <= 1'b0;
			iv_q    <= 1'b0;
			dz_q    <= 1'b0;
			rm_q    <= rm;
			if (nan_case) begin
				res_q  <= {NAN_MAN, {(RES_W-MAN_W){1'b0}}};
				rem_q  <= '0;
				exp_q  <= SPC_EXP;
				sgn_q  <= fp_format_pkg::QNAN_CANON[31];
				skip_q <= 1'b1;
				iv_q   <= invalid;
			end else if (inf_case) begin
				res_q  <= {INF_MAN, {(RES_W-MAN_W){1'b0}}};
				rem_q  <= '0;
				exp_q  <= SPC_EXP;
				skip_q <= 1'b1;
				dz_q   <= b.zero && !a.inf;	// inf/0 is exact
			end else if (zero_case) begin
				res_q  <= '0;
				rem_q  <= '0;
				exp_q  <= '0;
				skip_q <= 1'b1;
			end
		end else if (state == CALC) begin
			res_q <= {res_q[RES_W-3:0], qbits};
			rem_q <= step[2];
		end
	end

	// two restoring subtract steps per cycle against the divisor
	always_comb begin
		step[0] = rem_q;
		for (int i = 1; i <= 2; i++) begin
			diff[i]     = step[i-1] - {1'b0, div_man, 2'b00};
			qbits[2-i]  = !diff[i][REM_W-1];
			step[i]     = (diff[i][REM_W-1] ? step[i-1] : diff[i]) << 1;
		end
	end

	assign norm_shift = !res_q[RES_W-1] && !skip_q;	// quotient below one
	assign norm       = norm_shift ? {res_q[RES_W-2:0], 1'b0} : res_q;

	assign q.man        = norm[RES_W-1 -: MAN_W];
	assign q.round_bit  = norm[RES_W-MAN_W-1];
	assign q.sticky_bit = |norm[RES_W-MAN_W-2:0] || |rem_q;
	assign q.exp        = exp_q - {{(EXP_W-1){1'b0}}, norm_shift};
	assign q.sgn        = sgn_q;
	assign q.skip_round = skip_q;
	assign q.iv         = iv_q;
	assign q.dz         = dz_q;
	assign q.rm         = rm_q;
	assign q.valid      = valid_q;

endmodule

`default_nettype wire

// File: src/float_rounder.sv
`timescale 1ns/1ps
`default_nettype none

module float_rounder (
	input  wire logic   clk,
	input  wire logic   reset,
	fp_quotient_if.cons q,
	output logic        out_valid,
	input  wire logic   out_ready,
	output logic [31:0] result,
	output logic [4:0]  flags
);

	localparam int MAN_W  = fp_format_pkg::MAN_W;
	localparam int EXP_W  = fp_format_pkg::EXP_W;
	localparam int FRAC_W = fp_format_pkg::FRAC_W;
	localparam int BEXP_W = fp_format_pkg::BEXP_W;

	localparam logic signed [EXP_W-1:0] EXP_OVF =
		{{(EXP_W-BEXP_W){1'b0}}, fp_format_pkg::EXP_SPECIAL};

	logic signed [EXP_W-1:0]         exp_biased;
	logic signed [EXP_W-1:0]         exp_rnd;
	logic                            inexact;
	logic                            inc;
	logic [MAN_W:0]                  man_rnd;
	logic                            to_max;
	logic [31:0]                     result_d;
	logic [fpu_pkg::FLAG_W-1:0]      flags_d;
	logic                            take;

	assign q.ready = !out_valid || out_ready;	// one entry, may empty and refill at once
	assign take    = q.valid && q.ready;

	assign exp_biased = $signed(q.exp) + EXP_W'(fp_format_pkg::BIAS);
	assign inexact    = q.round_bit || q.sticky_bit;

	always_comb begin
		case (q.rm)
			fpu_pkg::RM_RTZ: inc = 1'b0;
			fpu_pkg::RM_RDN: inc = q.sgn && inexact;
			fpu_pkg::RM_RUP: inc = !q.sgn && inexact;
			fpu_pkg::RM_RMM: inc = q.round_bit;
			fpu_pkg::RM_RNE: inc = q.round_bit && (q.sticky_bit || q.man[0]);
			default:         inc = q.round_bit && (q.sticky_bit || q.man[0]);	// treated as RNE
		endcase
	end

	assign man_rnd = {1'b0, q.man} + {{MAN_W{1'b0}}, inc};
	assign exp_rnd = exp_biased + {{(EXP_W-1){1'b0}}, man_rnd[MAN_W]};	// carry out of rounding

	// overflow stops at the largest finite value when rounding goes toward zero
	assign to_max = q.rm == fpu_pkg::RM_RTZ ||
	                (q.rm == fpu_pkg::RM_RDN && !q.sgn) ||
	                (q.rm == fpu_pkg::RM_RUP && q.sgn);

	always_comb begin
		flags_d = '0;
		flags_d[fpu_pkg::FLAG_NV] = q.iv;
		flags_d[fpu_pkg::FLAG_DZ] = q.dz;
		if (q.skip_round) begin
			result_d = {q.sgn, q.exp[BEXP_W-1:0], q.man[FRAC_W-1:0]};
		end else if (exp_rnd >= EXP_OVF) begin
			flags_d[fpu_pkg::FLAG_OF] = 1'b1;
			flags_d[fpu_pkg::FLAG_NX] = 1'b1;
			if (to_max)
				result_d = {q.sgn, fp_format_pkg::EXP_MAXNORM, {FRAC_W{1'b1}}};
			else
				result_d = {q.sgn, fp_format_pkg::EXP_SPECIAL, {FRAC_W{1'b0}}};
		end else if (exp_rnd <= 0) begin
			flags_d[fpu_pkg::FLAG_UF] = 1'b1;
			flags_d[fpu_pkg::FLAG_NX] = 1'b1;
			result_d = {q.sgn, {(31){1'b0}}};	// no subnormal results
		end else begin
			flags_d[fpu_pkg::FLAG_NX] = inexact;
			result_d = {q.sgn, exp_rnd[BEXP_W-1:0], man_rnd[FRAC_W-1:0]};
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
			flags     <= '0;
		end else if (take) begin
			out_valid <= 1'b1;
			flags     <= flags_d;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			result <= result_d;
	end

endmodule

`default_nettype wire

// File: src/float_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module float_div_unit #(
	parameter int DIV_ITERS = 13
) (
	input  wire logic        clk,
	input  wire logic        reset,

	input  wire logic        in_valid,
	output logic             in_ready,
	input  wire logic [4:0]  op,
	input  wire logic [2:0]  rm,
	input  wire logic [31:0] a,
	input  wire logic [31:0] b,

	output logic             out_valid,
	input  wire logic        out_ready,
	output logic [31:0]      result,
	output logic [4:0]       flags
);

	fp_operand_if  opa ();
	fp_operand_if  opb ();
	fp_quotient_if quo ();

	float_unpacker unpack_a (
		.word (a),
		.op   (opa)
	);

	float_unpacker unpack_b (
		.word (b),
		.op   (opb)
	);

	float_divider #(
		.ITERS (DIV_ITERS)
	) divider (
		.clk      (clk),
		.reset    (reset),
		.op       (op),
		.rm       (rm),
		.a        (opa),
		.b        (opb),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.q        (quo)
	);

	float_rounder rounder (
		.clk       (clk),
		.reset     (reset),
		.q         (quo),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.flags     (flags)
	);

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;	// released away from the rising edge
	end

endmodule

`default_nettype wire

// File: verification/div_checker.sv
`timescale 1ns/1ps
`default_nettype none

module div_checker (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        in_valid,
	input  wire logic        in_ready,
	input  wire logic [4:0]  op,
	input  wire logic [2:0]  rm,
	input  wire logic [31:0] a,
	input  wire logic [31:0] b,
	input  wire logic        out_valid,
	input  wire logic        out_ready,
	input  wire logic [31:0] result,
	input  wire logic [4:0]  flags,
	input  wire logic [2:0]  test_id,
	input  wire logic        check_latency,
	output int               errors,
	output int               compared,
	output int               pending
);

	localparam int LAT_SPECIAL  = 2;
	localparam int LAT_ORDINARY = 15;

	logic [36:0] want_q [$];	// flags above the result word
	int          test_q [$];
	int          lat_q [$];	// -1 where the latency is not checked
	int          start_q [$];
	int          cycle;

	function automatic string test_name(input int id);
		case (id)
			1:       return "random";
			2:       return "special";
			3:       return "range";
			4:       return "backpressure";
			5:       return "bad_op";
			default: return "unknown";
		endcase
	endfunction

	function automatic logic [36:0] ref_div(input logic [31:0] x, input logic [31:0] y,
			input logic [2:0] mode, output bit special);
		logic        sr;
		logic        x_zero;
		logic        y_zero;
		logic        x_inf;
		logic        y_inf;
		logic        x_nan;
		logic        y_nan;
		logic        nv;
		logic        rnd;
		logic        stk;
		logic        inc;
		logic        to_max;
		logic [63:0] num;
		logic [63:0] den;
		logic [63:0] quo;
		logic [4:0]  fl;
		int          e;
		sr     = x[31] ^ y[31];
		x_zero = x[30:23] == 8'h00;	// subnormals count as zero
		y_zero = y[30:23] == 8'h00;
		x_inf  = x[30:23] == 8'hff && x[22:0] == 0;
		y_inf  = y[30:23] == 8'hff && y[22:0] == 0;
		x_nan  = x[30:23] == 8'hff && x[22:0] != 0;
		y_nan  = y[30:23] == 8'hff && y[22:0] != 0;
		nv     = (x_nan && !x[22]) || (y_nan && !y[22]) || (x_zero && y_zero) || (x_inf && y_inf);
		special = 1'b1;
		if (nv || x_nan || y_nan)
			return {nv, 4'b0000, 32'h7fc0_0000};
		if (x_inf || y_zero)
			return {1'b0, y_zero && !x_inf, 3'b000, sr, 8'hff, 23'd0};
		if (x_zero || y_inf)
			return {5'b00000, sr, 31'd0};
		special = 1'b0;
		num = {40'd0, 1'b1, x[22:0]};
		den = {40'd0, 1'b1, y[22:0]};
		e   = int'(x[30:23]) - int'(y[30:23]) + fp_format_pkg::BIAS;
		if (num >= den) begin
			num = num << 24;
		end else begin
			num = num << 25;	// quotient below one, take one more bit
			e   = e - 1;
		end
		quo = num / den;
		stk = (num % den) != 0;
		rnd = quo[0];
		quo = quo >> 1;
		case (mode)
			3'd1:    inc = 1'b0;
			3'd2:    inc = sr && (rnd || stk);
			3'd3:    inc = !sr && (rnd || stk);
			3'd4:    inc = rnd;
			default: inc = rnd && (stk || quo[0]);
		endcase
		quo = quo + inc;
		if (quo[24]) begin
			quo = quo >> 1;
			e   = e + 1;
		end
		fl = '0;
		if (e >= 255) begin
			fl[fpu_pkg::FLAG_OF] = 1'b1;
			fl[fpu_pkg::FLAG_NX] = 1'b1;
			to_max = mode == 3'd1 || (mode == 3'd2 && !sr) || (mode == 3'd3 && sr);
			return to_max ? {fl, sr, 8'hfe, {23{1'b1}}} : {fl, sr, 8'hff, 23'd0};
		end
		if (e <= 0) begin
			fl[fpu_pkg::FLAG_UF] = 1'b1;
			fl[fpu_pkg::FLAG_NX] = 1'b1;
			return {fl, sr, 31'd0};
		end
		fl[fpu_pkg::FLAG_NX] = rnd || stk;
		return {fl, sr, e[7:0], quo[22:0]};
	endfunction

	always @(posedge clk) begin : compare
		logic [36:0] want;
		bit          special;
		int          lat;
		int          start;
		string       name;
		if (reset) begin
			cycle    = 0;
			errors   = 0;
			compared = 0;
			pending  = 0;
		end else begin
			if (out_valid && out_ready) begin
				if (want_q.size() == 0) begin
					$display("ERROR: result %h was delivered with no operation pending", result);
					errors++;
				end else begin
					want  = want_q.pop_front();
					name  = test_name(test_q.pop_front());
					lat   = lat_q.pop_front();
					start = start_q.pop_front();
					compared++;
					if ({flags, result} !== want) begin
						$display("CHECK FAILED %s: expected %h flags %b, actual %h flags %b",
							name, want[31:0], want[36:32], result, flags);
						errors++;
					end
					if (lat >= 0 && cycle - start != lat) begin
						$display("CHECK FAILED %s latency: expected %0d, actual %0d",
							name, lat, cycle - start);
						errors++;
					end
				end
			end
			if (in_valid && in_ready) begin
				if (op != fpu_pkg::FPU_OP_DIV) begin
					$display("ERROR: an operation with op code %0d was accepted", op);
					errors++;
				end else begin
					want = ref_div(a, b, rm, special);
					want_q.push_back(want);
					test_q.push_back(test_id);
					lat_q.push_back(!check_latency ? -1 : special ? LAT_SPECIAL : LAT_ORDINARY);
					start_q.push_back(cycle);
				end
			end
			pending = want_q.size();
			cycle++;
		end
	end

endmodule

`default_nettype wire

// File: verification/float_div_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module float_div_unit_asserts (
	input wire logic        clk,
	input wire logic        reset,
	input wire logic [4:0]  op,
	input wire logic        in_ready,
	input wire logic        out_valid,
	input wire logic        out_ready,
	input wire logic [31:0] result,
	input wire logic [4:0]  flags
);

	int fails = 0;	// read by the testbench top for its verdict

	// a stalled result must not move until it is taken
	hold_result: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags))
		else begin
			$error("result changed or vanished while out_ready was low");
			fails++;
		end

	div_only: assert property (@(posedge clk) disable iff (reset)
		op != fpu_pkg::FPU_OP_DIV |-> !in_ready)
		else begin
			$error("in_ready high for an op code other than divide");
			fails++;
		end

	idle_after_reset: assert property (@(posedge clk)
		reset |=> !out_valid)
		else begin
			$error("out_valid high right after reset");
			fails++;
		end

endmodule

`default_nettype wire

// File: verification/tb_float_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_float_div_unit;

	localparam int N_RANDOM  = 60;
	localparam int N_SPECIAL = 14;
	localparam int N_RANGE   = 16;
	localparam int N_BACK    = 40;
	localparam int N_OPS     = N_RANDOM + N_SPECIAL + N_RANGE + N_BACK + 1;
	localparam int WATCHDOG  = N_OPS * 20 + 200;

	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	logic [4:0]  op;
	logic [2:0]  rm;
	logic [31:0] a;
	logic [31:0] b;
	logic        out_valid;
	logic        out_ready = 1'b1;
	logic [31:0] result;
	logic [4:0]  flags;
	logic [2:0]  test_id;
	logic        check_latency;
	logic        back_pressure;
	logic        fire;
	int          errors;
	int          compared;
	int          pending;

	logic [2:0]  modes [0:5] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};	// 7 acts as RNE
	logic [31:0] spec_a [0:N_SPECIAL-1] = '{
		32'h0000_0000, 32'h7f80_0000, 32'h7f80_0001, 32'h3f80_0000, 32'h7fc1_2345,
		32'h3f80_0000, 32'h4040_0000, 32'hc040_0000, 32'h8000_0000, 32'h4000_0000,
		32'h0001_2345, 32'h4000_0000, 32'h7f80_0000, 32'hff80_0000};
	logic [31:0] spec_b [0:N_SPECIAL-1] = '{
		32'h8000_0000, 32'hff80_0000, 32'h3f80_0000, 32'h7f80_0001, 32'h3f80_0000,
		32'hffc0_0001, 32'h0000_0000, 32'h0000_0000, 32'h4000_0000, 32'hff80_0000,
		32'h4000_0000, 32'h8000_0123, 32'h4000_0000, 32'h0000_0000};

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) clock_gen (.clk(clk), .reset(reset));

	float_div_unit uut (
		.clk (clk), .reset (reset),
		.in_valid (in_valid), .in_ready (in_ready), .op (op), .rm (rm), .a (a), .b (b),
		.out_valid (out_valid), .out_ready (out_ready), .result (result), .flags (flags)
	);

	div_checker scoreboard (
		.clk (clk), .reset (reset), .in_valid (in_valid), .in_ready (in_ready),
		.op (op), .rm (rm), .a (a), .b (b), .out_valid (out_valid), .out_ready (out_ready),
		.result (result), .flags (flags), .test_id (test_id), .check_latency (check_latency),
		.errors (errors), .compared (compared), .pending (pending)
	);

	bind float_div_unit float_div_unit_asserts asserts (
		.clk (clk), .reset (reset), .op (op), .in_ready (in_ready), .out_valid (out_valid),
		.out_ready (out_ready), .result (result), .flags (flags)
	);

	always @(posedge clk) fire <= in_valid && in_ready;

	always @(negedge clk) out_ready <= !back_pressure || $urandom % 3 != 0;

	function automatic logic [31:0] random_normal(input int lo, input int hi);
		logic [31:0] r;
		r = $urandom;
		r[30:23] = 8'(lo + $urandom % (hi - lo + 1));
		return r;
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input logic [31:0] x, input logic [31:0] y, input logic [2:0] mode);
		in_valid = 1'b1;
		a        = x;
		b        = y;
		rm       = mode;
		@(negedge clk);
		while (!fire) @(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (pending != 0) @(negedge clk);
	endtask

	initial begin : stimulus
		logic [31:0] x;
		logic [31:0] y;
		void'($urandom(32'hf131_e09a));
		in_valid      = 1'b0;
		op            = fpu_pkg::FPU_OP_DIV;
		rm            = 3'd0;
		a             = '0;
		b             = '0;
		test_id       = 3'd1;
		check_latency = 1'b1;
		back_pressure = 1'b0;
		wait (!reset);
		@(negedge clk);
		for (int i = 0; i < N_RANDOM; i++)
			issue(random_normal(64, 190), random_normal(64, 190), modes[$urandom % 6]);
		drain();
		test_id = 3'd2;
		for (int i = 0; i < N_SPECIAL; i++)
			issue(spec_a[i], spec_b[i], modes[$urandom % 6]);
		drain();
		test_id = 3'd3;
		for (int i = 0; i < N_RANGE; i++) begin
			x = random_normal(i < 12 ? 254 : 1, i < 12 ? 254 : 1);	// huge over tiny, then reverse
			y = random_normal(i < 12 ? 1 : 254, i < 12 ? 1 : 254);
			x[31] = i % 12 >= 6;
			issue(x, y, modes[i % 6]);
		end
		drain();
		test_id       = 3'd4;
		check_latency = 1'b0;
		back_pressure = 1'b1;
		for (int i = 0; i < N_BACK; i++) begin
			if ($urandom % 4 == 0)
				issue(spec_a[$urandom % N_SPECIAL], spec_b[$urandom % N_SPECIAL], 3'd0);
			else
				issue(random_normal(1, 254), random_normal(1, 254), modes[$urandom % 6]);
		end
		drain();
		back_pressure = 1'b0;
		test_id  = 3'd5;
		op       = fpu_pkg::FPU_OP_MUL;
		in_valid = 1'b1;
		repeat (12) @(negedge clk);
		in_valid = 1'b0;
		op       = fpu_pkg::FPU_OP_DIV;
		repeat (20) @(negedge clk);
		drain();
		$display("compared %0d results, %0d errors, %0d assertion failures, %0d still pending",
			compared, errors, uut.asserts.fails, pending);
		if (errors == 0 && pending == 0 && uut.asserts.fails == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG) @(posedge clk);
		$display("ERROR: the run did not finish within %0d cycles", WATCHDOG);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: float_div_unit.f
common/fpu_pkg.sv
common/fp_format_pkg.sv
common/fp_operand_if.sv
common/fp_quotient_if.sv
src/float_unpacker.sv
float_divider/float_divider.sv
src/float_rounder.sv
src/float_div_unit.sv
verification/tb_clock_gen.sv
verification/div_checker.sv
verification/float_div_unit_asserts.sv
verification/tb_float_div_unit.sv

// File: Bender.yml
package:
  name: float_div_unit

sources:
  - files:
      - common/fpu_pkg.sv
      - common/fp_format_pkg.sv
      - common/fp_operand_if.sv
      - common/fp_quotient_if.sv
      - src/float_unpacker.sv
      - float_divider/float_divider.sv
      - src/float_rounder.sv
      - src/float_div_unit.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/div_checker.sv
      - verification/float_div_unit_asserts.sv
      - verification/tb_float_div_unit.sv
